// ==== design/warp_pkg.sv ====
`default_nettype none

package warp_pkg;

	// core geometry
	localparam int NUM_WARPS    = 4;
	localparam int NUM_THREADS  = 4;
	localparam int NUM_BARRIERS = 2;

	// request buffer depth, also the sender's starting credits
	localparam int REQ_CREDITS  = 2;

	typedef logic [$clog2(NUM_WARPS)-1:0]    warp_id_t;
	typedef logic [NUM_WARPS-1:0]            warp_mask_t;
	typedef logic [NUM_THREADS-1:0]          thread_mask_t;

	// 0 .. NUM_WARPS inclusive
	typedef logic [$clog2(NUM_WARPS):0]      warp_cnt_t;

	typedef logic [31:0]                     word_t;
	typedef logic [31:0]                     pc_t;

	// lane t sits at bits [t*32 +: 32]
	typedef logic [NUM_THREADS*32-1:0]       lane_data_t;

	typedef logic [$clog2(NUM_BARRIERS)-1:0] barrier_id_t;
	typedef logic [2:0]                      opcode_t;

	// control opcodes
	localparam opcode_t OP_TMC    = 3'd0;
	localparam opcode_t OP_WSPAWN = 3'd1;
	localparam opcode_t OP_SPLIT  = 3'd2;
	localparam opcode_t OP_JOIN   = 3'd3;
	localparam opcode_t OP_BAR    = 3'd4;

endpackage

`default_nettype wire

// ==== design/gpgpu_inst.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpgpu_inst (
	input  warp_pkg::opcode_t      op,
	input  warp_pkg::thread_mask_t valids,
	input  warp_pkg::lane_data_t   rs1,
	input  warp_pkg::word_t        rs2,
	input  warp_pkg::pc_t          pc_next,

	output logic                   do_tmc,
	output warp_pkg::thread_mask_t tmc_mask,
	output logic                   ebreak_req,

	output logic                   do_wspawn,
	output warp_pkg::warp_mask_t   spawn_mask,
	output warp_pkg::pc_t          spawn_pc,

	output logic                   do_split,
	output logic                   dont_split,
	output warp_pkg::thread_mask_t split_use_mask,
	output warp_pkg::thread_mask_t split_later_mask,
	output warp_pkg::pc_t          split_pc,

	output logic                   do_join,
	output logic                   do_bar,
	output warp_pkg::barrier_id_t  bar_id
);
	import warp_pkg::*;

	logic                         valid_inst;
	word_t                        n_arg;
	thread_mask_t                 new_tmask;
	warp_mask_t                   new_active;
	thread_mask_t                 cond_true;
	thread_mask_t                 use_mask;
	thread_mask_t                 later_mask;
	logic [$clog2(NUM_THREADS):0] num_valids;

	// nothing happens without at least one live thread
	assign valid_inst = |valids;
	assign n_arg      = rs1[31:0];

	// low n bits; n past the width naturally fills every bit
	always_comb begin
		for (int t = 0; t < NUM_THREADS; t++) begin
			new_tmask[t] = t < n_arg;
		end
		for (int w = 0; w < NUM_WARPS; w++) begin
			new_active[w] = w < n_arg;
		end
	end

	// per-lane branch condition and valid count
	always_comb begin
		num_valids = '0;
		for (int t = 0; t < NUM_THREADS; t++) begin
			cond_true[t] = rs1[t*32 +: 32] == 32'd1;
			num_valids   = num_valids + {{$clog2(NUM_THREADS){1'b0}}, valids[t]};
		end
	end

	assign use_mask   = valids & cond_true;
	assign later_mask = valids & ~cond_true;

	assign do_tmc     = (op == OP_TMC) && valid_inst;
	assign tmc_mask   = do_tmc ? new_tmask : '0;
	assign ebreak_req = do_tmc && (tmc_mask == '0);

	assign do_wspawn  = (op == OP_WSPAWN) && valid_inst;
	assign spawn_mask = do_wspawn ? new_active : '0;
	assign spawn_pc   = do_wspawn ? rs2 : '0;

	// a single live thread cannot diverge
	assign do_split         = (op == OP_SPLIT) && (num_valids > 1);
	assign dont_split       = do_split && ((use_mask == '0) || (later_mask == '0));
	assign split_use_mask   = do_split ? use_mask : '0;
	assign split_later_mask = do_split ? later_mask : '0;
	assign split_pc         = do_split ? pc_next : '0;

	assign do_join = (op == OP_JOIN) && valid_inst;
	assign do_bar  = (op == OP_BAR) && valid_inst;
	assign bar_id  = do_bar ? rs1[$bits(barrier_id_t)-1:0] : '0;

endmodule

`default_nettype wire

// ==== design/warp_ctl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_ctl_fsm (
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   req_valid,
	input  warp_pkg::opcode_t      req_op,
	input  warp_pkg::warp_id_t     req_warp,
	input  warp_pkg::thread_mask_t req_valids,
	input  warp_pkg::lane_data_t   req_rs1,
	input  warp_pkg::word_t        req_rs2,
	input  warp_pkg::pc_t          req_pc_next,

	input  logic                   do_tmc,
	input  logic                   ebreak_req,
	input  logic                   do_wspawn,
	input  warp_pkg::warp_mask_t   spawn_mask,
	input  logic                   do_split,
	input  logic                   do_join,
	input  logic                   do_bar,
	input  warp_pkg::warp_id_t     spawn_idx,
	input  logic                   spawn_last,

	output logic                   credit_return,
	output logic                   ebreak,
	output warp_pkg::opcode_t      head_op,
	output warp_pkg::thread_mask_t head_valids,
	output warp_pkg::lane_data_t   head_rs1,
	output warp_pkg::word_t        head_rs2,
	output warp_pkg::pc_t          head_pc_next,
	output warp_pkg::warp_id_t     head_warp,
	output logic                   wr_tmask,
	output logic                   wr_active,
	output logic                   wr_pc,
	output logic                   push_split,
	output logic                   pop_join,
	output logic                   bar_arrive,
	output logic                   spawn_start
);
	import warp_pkg::*;

	localparam int PTR_W = $clog2(REQ_CREDITS);

	typedef enum logic {IDLE, SPAWN} seq_state_t;

	seq_state_t       state;
	seq_state_t       next_state;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;

	opcode_t      fifo_op     [REQ_CREDITS];
	warp_id_t     fifo_warp   [REQ_CREDITS];
	thread_mask_t fifo_valids [REQ_CREDITS];
	lane_data_t   fifo_rs1    [REQ_CREDITS];
	word_t        fifo_rs2    [REQ_CREDITS];
	pc_t          fifo_pc     [REQ_CREDITS];

	// head of buffer goes out to the decoder
	assign head_op      = fifo_op[rd_ptr];
	assign head_warp    = fifo_warp[rd_ptr];
	assign head_valids  = fifo_valids[rd_ptr];
	assign head_rs1     = fifo_rs1[rd_ptr];
	assign head_rs2     = fifo_rs2[rd_ptr];
	assign head_pc_next = fifo_pc[rd_ptr];

	// credits guarantee a free slot on every push
	always_ff @(posedge clk) begin
		if (req_valid) begin
			fifo_op[wr_ptr]     <= req_op;
			fifo_warp[wr_ptr]   <= req_warp;
			fifo_valids[wr_ptr] <= req_valids;
			fifo_rs1[wr_ptr]    <= req_rs1;
			fifo_rs2[wr_ptr]    <= req_rs2;
			fifo_pc[wr_ptr]     <= req_pc_next;
		end
	end

	always_comb begin
		next_state    = state;
		credit_return = 1'b0;
		ebreak        = 1'b0;
		wr_tmask      = 1'b0;
		wr_active     = 1'b0;
		wr_pc         = 1'b0;
		push_split    = 1'b0;
		pop_join      = 1'b0;
		bar_arrive    = 1'b0;
		spawn_start   = 1'b0;
		if (state == IDLE) begin
			if (count != '0) begin
				if (do_wspawn) begin
					// head stays put until the walk finishes
					spawn_start = 1'b1;
					next_state  = SPAWN;
				end else begin
					credit_return = 1'b1;
					wr_tmask      = do_tmc;
					ebreak        = ebreak_req;
					push_split    = do_split;
					pop_join      = do_join;
					bar_arrive    = do_bar;
				end
			end
		end else begin
			wr_pc = spawn_mask[spawn_idx];
			if (spawn_last) begin
				credit_return = 1'b1;
				wr_active     = 1'b1;
				next_state    = IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= IDLE;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			state <= next_state;
			if (req_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (credit_return) begin
				rd_ptr <= (rd_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + {{PTR_W{1'b0}}, req_valid} - {{PTR_W{1'b0}}, credit_return};
		end
	end

endmodule

`default_nettype wire

// ==== design/spawn_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spawn_counter (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               spawn_start,
	output warp_pkg::warp_id_t spawn_idx,
	output logic               spawn_last
);
	import warp_pkg::*;

	logic running;

	assign spawn_last = running && (spawn_idx == warp_id_t'(NUM_WARPS - 1));

	// one warp index per cycle, idle again after the last one
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running   <= 1'b0;
			spawn_idx <= '0;
		end else if (spawn_start) begin
			running   <= 1'b1;
			spawn_idx <= '0;
		end else if (running) begin
			if (spawn_last) begin
				running <= 1'b0;
			end else begin
				spawn_idx <= spawn_idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/warp_state_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_state_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  warp_pkg::warp_id_t     head_warp,
	input  logic                   wr_tmask,
	input  warp_pkg::thread_mask_t tmc_mask,
	input  logic                   wr_active,
	input  warp_pkg::warp_mask_t   spawn_mask,
	input  warp_pkg::warp_id_t     spawn_idx,
	input  logic                   wr_pc,
	input  warp_pkg::pc_t          spawn_pc,
	input  logic                   push_split,
	input  logic                   dont_split,
	input  warp_pkg::thread_mask_t split_use_mask,
	input  warp_pkg::thread_mask_t split_later_mask,
	input  warp_pkg::pc_t          split_pc,
	input  logic                   pop_join,
	input  warp_pkg::warp_mask_t   release_mask,
	input  logic                   bar_arrive,
	input  warp_pkg::warp_id_t     query_warp,
	output warp_pkg::warp_mask_t   warp_active,
	output warp_pkg::thread_mask_t query_tmask,
	output warp_pkg::pc_t          query_pc
);
	import warp_pkg::*;

	thread_mask_t tmask      [NUM_WARPS];
	pc_t          pc         [NUM_WARPS];
	thread_mask_t slot_later [NUM_WARPS];
	thread_mask_t slot_orig  [NUM_WARPS];
	pc_t          slot_pc    [NUM_WARPS];
	warp_mask_t   slot_full;
	warp_mask_t   slot_second;
	warp_mask_t   parked;
	warp_mask_t   arrive_bit;
	logic         head_free;
	logic         do_push;

	// a warp parked at a barrier holds its masks until released
	assign head_free  = !parked[head_warp];
	assign arrive_bit = bar_arrive ? (warp_mask_t'(1) << head_warp) : '0;
	assign do_push    = push_split && !dont_split && head_free;

	assign query_tmask = tmask[query_warp];
	assign query_pc    = pc[query_warp];

	always_ff @(posedge clk) begin
		if (do_push) begin
			slot_later[head_warp] <= split_later_mask;
			slot_orig[head_warp]  <= tmask[head_warp];
			slot_pc[head_warp]    <= split_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int w = 0; w < NUM_WARPS; w++) begin
				tmask[w] <= (w == 0) ? thread_mask_t'(1) : '0;
				pc[w]    <= '0;
			end
			warp_active <= warp_mask_t'(1);
			slot_full   <= '0;
			slot_second <= '0;
			parked      <= '0;
		end else begin
			if (wr_tmask && head_free) begin
				tmask[head_warp] <= tmc_mask;
				// empty mask retires the warp
				if (tmc_mask == '0) begin
					warp_active[head_warp] <= 1'b0;
				end
			end
			if (do_push) begin
				tmask[head_warp]       <= split_use_mask;
				slot_full[head_warp]   <= 1'b1;
				slot_second[head_warp] <= 1'b0;
			end
			if (pop_join && head_free && slot_full[head_warp]) begin
				if (!slot_second[head_warp]) begin
					tmask[head_warp]       <= slot_later[head_warp];
					pc[head_warp]          <= slot_pc[head_warp];
					slot_second[head_warp] <= 1'b1;
				end else begin
					tmask[head_warp]       <= slot_orig[head_warp];
					slot_full[head_warp]   <= 1'b0;
					slot_second[head_warp] <= 1'b0;
				end
			end
			// spawned warps start with a single thread
			if (wr_pc) begin
				pc[spawn_idx]    <= spawn_pc;
				tmask[spawn_idx] <= thread_mask_t'(1);
			end
			if (wr_active) begin
				warp_active <= spawn_mask;
			end
			parked <= (parked | arrive_bit) & ~release_mask;
		end
	end

endmodule

`default_nettype wire

// ==== design/barrier_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrier_table (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  bar_arrive,
	input  warp_pkg::barrier_id_t bar_id,
	input  warp_pkg::warp_id_t    bar_warp,
	input  warp_pkg::warp_cnt_t   num_active,
	output warp_pkg::warp_mask_t  stalled_mask,
	output warp_pkg::warp_mask_t  release_mask
);
	import warp_pkg::*;

	warp_cnt_t   arrive_cnt [NUM_BARRIERS];
	barrier_id_t warp_bar   [NUM_WARPS];
	warp_cnt_t   next_cnt;
	warp_mask_t  arrive_bit;
	logic        bar_done;

	assign next_cnt   = arrive_cnt[bar_id] + warp_cnt_t'(1);
	assign bar_done   = bar_arrive && (next_cnt >= num_active);
	assign arrive_bit = bar_arrive ? (warp_mask_t'(1) << bar_warp) : '0;

	// last arrival frees every warp waiting on the same id, itself included
	always_comb begin
		release_mask = '0;
		if (bar_done) begin
			for (int w = 0; w < NUM_WARPS; w++) begin
				release_mask[w] = stalled_mask[w] && (warp_bar[w] == bar_id);
			end
			release_mask[bar_warp] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (bar_arrive) begin
			warp_bar[bar_warp] <= bar_id;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int b = 0; b < NUM_BARRIERS; b++) begin
				arrive_cnt[b] <= '0;
			end
			stalled_mask <= '0;
		end else begin
			if (bar_arrive) begin
				arrive_cnt[bar_id] <= bar_done ? '0 : next_cnt;
			end
			stalled_mask <= (stalled_mask | arrive_bit) & ~release_mask;
		end
	end

endmodule

`default_nettype wire

// ==== design/warp_ctl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_ctl_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req_valid,
	input  warp_pkg::opcode_t      req_op,
	input  warp_pkg::warp_id_t     req_warp,
	input  warp_pkg::thread_mask_t req_valids,
	input  warp_pkg::lane_data_t   req_rs1,
	input  warp_pkg::word_t        req_rs2,
	input  warp_pkg::pc_t          req_pc_next,
	output logic                   credit_return,
	output warp_pkg::warp_mask_t   warp_active,
	output warp_pkg::warp_mask_t   warp_stalled,
	output logic                   ebreak,
	input  warp_pkg::warp_id_t     query_warp,
	output warp_pkg::thread_mask_t query_tmask,
	output warp_pkg::pc_t          query_pc
);
	import warp_pkg::*;

	// buffered head
	opcode_t      head_op;
	thread_mask_t head_valids;
	lane_data_t   head_rs1;
	word_t        head_rs2;
	pc_t          head_pc_next;
	warp_id_t     head_warp;

	// decoded fields
	logic         do_tmc, ebreak_req, do_wspawn, do_split, dont_split, do_join, do_bar;
	thread_mask_t tmc_mask, split_use_mask, split_later_mask;
	warp_mask_t   spawn_mask;
	pc_t          spawn_pc, split_pc;
	barrier_id_t  bar_id;

	// strobes and feedback
	logic         wr_tmask, wr_active, wr_pc, push_split, pop_join, bar_arrive;
	logic         spawn_start, spawn_last;
	warp_id_t     spawn_idx;
	warp_mask_t   release_mask;
	warp_cnt_t    num_active;

	assign num_active = warp_cnt_t'($countones(warp_active));

	gpgpu_inst u_inst (
		.op(head_op), .valids(head_valids), .rs1(head_rs1), .rs2(head_rs2),
		.pc_next(head_pc_next), .do_tmc(do_tmc), .tmc_mask(tmc_mask),
		.ebreak_req(ebreak_req), .do_wspawn(do_wspawn), .spawn_mask(spawn_mask),
		.spawn_pc(spawn_pc), .do_split(do_split), .dont_split(dont_split),
		.split_use_mask(split_use_mask), .split_later_mask(split_later_mask),
		.split_pc(split_pc), .do_join(do_join), .do_bar(do_bar), .bar_id(bar_id)
	);

	warp_ctl_fsm u_fsm (
		.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_op(req_op),
		.req_warp(req_warp), .req_valids(req_valids), .req_rs1(req_rs1),
		.req_rs2(req_rs2), .req_pc_next(req_pc_next), .do_tmc(do_tmc),
		.ebreak_req(ebreak_req), .do_wspawn(do_wspawn), .spawn_mask(spawn_mask),
		.do_split(do_split), .do_join(do_join), .do_bar(do_bar),
		.spawn_idx(spawn_idx), .spawn_last(spawn_last), .credit_return(credit_return),
		.ebreak(ebreak), .head_op(head_op), .head_valids(head_valids),
		.head_rs1(head_rs1), .head_rs2(head_rs2), .head_pc_next(head_pc_next),
		.head_warp(head_warp), .wr_tmask(wr_tmask), .wr_active(wr_active),
		.wr_pc(wr_pc), .push_split(push_split), .pop_join(pop_join),
		.bar_arrive(bar_arrive), .spawn_start(spawn_start)
	);

	spawn_counter u_spawn (
		.clk(clk), .rst_n(rst_n), .spawn_start(spawn_start),
		.spawn_idx(spawn_idx), .spawn_last(spawn_last)
	);

	warp_state_regs u_state (
		.clk(clk), .rst_n(rst_n), .head_warp(head_warp), .wr_tmask(wr_tmask),
		.tmc_mask(tmc_mask), .wr_active(wr_active), .spawn_mask(spawn_mask),
		.spawn_idx(spawn_idx), .wr_pc(wr_pc), .spawn_pc(spawn_pc),
		.push_split(push_split), .dont_split(dont_split),
		.split_use_mask(split_use_mask), .split_later_mask(split_later_mask),
		.split_pc(split_pc), .pop_join(pop_join), .release_mask(release_mask),
		.bar_arrive(bar_arrive), .query_warp(query_warp), .warp_active(warp_active),
		.query_tmask(query_tmask), .query_pc(query_pc)
	);

	barrier_table u_bar (
		.clk(clk), .rst_n(rst_n), .bar_arrive(bar_arrive), .bar_id(bar_id),
		.bar_warp(head_warp), .num_active(num_active),
		.stalled_mask(warp_stalled), .release_mask(release_mask)
	);

endmodule

`default_nettype wire

// ==== tb/warp_ctl_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_ctl_props (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 req_valid,
	input logic                 credit_return,
	input logic                 ebreak,
	input warp_pkg::warp_mask_t warp_active,
	input warp_pkg::warp_mask_t warp_stalled
);
	import warp_pkg::*;

	// requests accepted but not yet returned
	int outstanding;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(req_valid) - int'(credit_return);
		end
	end

	reset_state: assert property (@(posedge clk)
		!rst_n |=> (warp_active == warp_mask_t'(1)) && !credit_return && !ebreak
			&& (warp_stalled == '0))
		else $error("outputs not at reset values after a reset cycle");

	// the head entry gives its credit back within one spawn walk
	return_in_time: assert property (@(posedge clk) disable iff (!rst_n)
		(outstanding != 0) |-> ##[0:NUM_WARPS] credit_return)
		else $error("credit not returned while requests were outstanding");

	return_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		credit_return |-> outstanding > 0)
		else $error("credit returned without an outstanding request");

endmodule

bind warp_ctl_top warp_ctl_props i_props (
	.clk(clk),
	.rst_n(rst_n),
	.req_valid(req_valid),
	.credit_return(credit_return),
	.ebreak(ebreak),
	.warp_active(warp_active),
	.warp_stalled(warp_stalled)
);

`default_nettype wire

// ==== tb/warp_ctl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_ctl_tb;
	import warp_pkg::*;

	localparam int CLK_PERIOD     = 10;
	localparam int NUM_DIRECTED   = 14;
	localparam int NUM_RANDOM     = 36;
	localparam int NUM_REQS       = NUM_DIRECTED + NUM_RANDOM;
	localparam int TIMEOUT_CYCLES = NUM_REQS * (NUM_WARPS + 4) + 500;

	typedef struct packed {
		opcode_t      op;
		warp_id_t     warp;
		thread_mask_t valids;
		lane_data_t   rs1;
		word_t        rs2;
		pc_t          pc_next;
	} req_t;

	logic         clk;
	logic         rst_n;
	logic         req_valid;
	opcode_t      req_op;
	warp_id_t     req_warp;
	thread_mask_t req_valids;
	lane_data_t   req_rs1;
	word_t        req_rs2;
	pc_t          req_pc_next;
	logic         credit_return;
	warp_mask_t   warp_active;
	warp_mask_t   warp_stalled;
	logic         ebreak;
	warp_id_t     query_warp;
	thread_mask_t query_tmask;
	pc_t          query_pc;

	integer seed;
	int     credits;
	req_t   pending[$];
	logic   exp_ebreak;

	// reference model of the warp state
	warp_mask_t   m_active;
	warp_mask_t   m_stalled;
	thread_mask_t m_tmask      [NUM_WARPS];
	pc_t          m_pc         [NUM_WARPS];
	thread_mask_t m_slot_later [NUM_WARPS];
	thread_mask_t m_slot_orig  [NUM_WARPS];
	pc_t          m_slot_pc    [NUM_WARPS];
	logic         m_slot_full  [NUM_WARPS];
	logic         m_slot_second[NUM_WARPS];
	barrier_id_t  m_bar_of     [NUM_WARPS];
	int           m_bar_cnt    [NUM_BARRIERS];

	warp_ctl_top i_dut (
		.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_op(req_op),
		.req_warp(req_warp), .req_valids(req_valids), .req_rs1(req_rs1),
		.req_rs2(req_rs2), .req_pc_next(req_pc_next), .credit_return(credit_return),
		.warp_active(warp_active), .warp_stalled(warp_stalled), .ebreak(ebreak),
		.query_warp(query_warp), .query_tmask(query_tmask), .query_pc(query_pc)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, %0d requests still pending",
			TIMEOUT_CYCLES, pending.size());
		stop_with_failure();
	end

	task automatic stop_with_failure();
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("ERROR %0t ns %s got %h expected %h", $time, name, got, want);
		stop_with_failure();
	endtask

	// low n bits set, saturating at the full width
	function automatic thread_mask_t thread_fill(input word_t n);
		if (n >= NUM_THREADS) begin
			return '1;
		end
		return thread_mask_t'((32'd1 << n) - 32'd1);
	endfunction

	function automatic warp_mask_t warp_fill(input word_t n);
		if (n >= NUM_WARPS) begin
			return '1;
		end
		return warp_mask_t'((32'd1 << n) - 32'd1);
	endfunction

	function automatic lane_data_t pack_lanes(input word_t l3, input word_t l2,
			input word_t l1, input word_t l0);
		return {l3, l2, l1, l0};
	endfunction

	task automatic reset_model();
		m_active  = warp_mask_t'(1);
		m_stalled = '0;
		for (int w = 0; w < NUM_WARPS; w++) begin
			m_tmask[w]       = (w == 0) ? thread_mask_t'(1) : '0;
			m_pc[w]          = '0;
			m_slot_full[w]   = 1'b0;
			m_slot_second[w] = 1'b0;
			m_bar_of[w]      = '0;
		end
		for (int b = 0; b < NUM_BARRIERS; b++) begin
			m_bar_cnt[b] = 0;
		end
	endtask

	task automatic apply_request(input req_t r);
		thread_mask_t cond;
		thread_mask_t use_m;
		thread_mask_t later_m;
		warp_mask_t   spawn_m;
		barrier_id_t  id;
		word_t        n;
		n = r.rs1[31:0];
		for (int t = 0; t < NUM_THREADS; t++) begin
			cond[t] = r.rs1[t*32 +: 32] == 32'd1;
		end
		use_m   = r.valids & cond;
		later_m = r.valids & ~cond;
		id      = r.rs1[0];
		if (r.valids != '0) begin
			case (r.op)
				OP_TMC: begin
					m_tmask[r.warp] = thread_fill(n);
					if (m_tmask[r.warp] == '0) begin
						m_active[r.warp] = 1'b0;
					end
				end
				OP_WSPAWN: begin
					spawn_m = warp_fill(n);
					for (int w = 0; w < NUM_WARPS; w++) begin
						if (spawn_m[w]) begin
							m_pc[w]    = r.rs2;
							m_tmask[w] = thread_mask_t'(1);
						end
					end
					m_active = spawn_m;
				end
				OP_SPLIT: begin
					// diverges only when both paths keep a thread
					if ($countones(r.valids) > 1 && use_m != '0 && later_m != '0) begin
						m_slot_later[r.warp]  = later_m;
						m_slot_orig[r.warp]   = m_tmask[r.warp];
						m_slot_pc[r.warp]     = r.pc_next;
						m_slot_full[r.warp]   = 1'b1;
						m_slot_second[r.warp] = 1'b0;
						m_tmask[r.warp]       = use_m;
					end
				end
				OP_JOIN: begin
					if (m_slot_full[r.warp] && !m_slot_second[r.warp]) begin
						m_tmask[r.warp]       = m_slot_later[r.warp];
						m_pc[r.warp]          = m_slot_pc[r.warp];
						m_slot_second[r.warp] = 1'b1;
					end else if (m_slot_full[r.warp]) begin
						m_tmask[r.warp]       = m_slot_orig[r.warp];
						m_slot_full[r.warp]   = 1'b0;
						m_slot_second[r.warp] = 1'b0;
					end
				end
				OP_BAR: begin
					m_stalled[r.warp] = 1'b1;
					m_bar_of[r.warp]  = id;
					m_bar_cnt[id]++;
					if (m_bar_cnt[id] >= $countones(m_active)) begin
						for (int w = 0; w < NUM_WARPS; w++) begin
							if (m_stalled[w] && m_bar_of[w] == id) begin
								m_stalled[w] = 1'b0;
							end
						end
						m_bar_cnt[id] = 0;
					end
				end
				default: ;
			endcase
		end
	endtask

	// checks against the model, then model update on each applied entry
	always @(posedge clk) begin
		if (!rst_n) begin
			reset_model();
			credits = REQ_CREDITS;
			pending.delete();
		end else begin
			if (pending.size() == 0) begin
				assert (warp_active == m_active)
					else report_mismatch("warp_active", 32'(warp_active), 32'(m_active));
				assert (warp_stalled == m_stalled)
					else report_mismatch("warp_stalled", 32'(warp_stalled), 32'(m_stalled));
				assert (query_tmask == m_tmask[query_warp])
					else report_mismatch("query_tmask", 32'(query_tmask),
						32'(m_tmask[query_warp]));
				assert (query_pc == m_pc[query_warp])
					else report_mismatch("query_pc", query_pc, m_pc[query_warp]);
			end
			exp_ebreak = 1'b0;
			if (credit_return && pending.size() != 0) begin
				exp_ebreak = (pending[0].op == OP_TMC) && (pending[0].valids != '0)
					&& (pending[0].rs1[31:0] == 32'd0);
			end
			assert (ebreak == exp_ebreak)
				else report_mismatch("ebreak", 32'(ebreak), 32'(exp_ebreak));
			if (credit_return) begin
				if (pending.size() == 0) begin
					$display("credit_return pulsed at %0t ns with no request outstanding", $time);
					stop_with_failure();
				end else begin
					apply_request(pending.pop_front());
				end
			end
			if (req_valid) begin
				pending.push_back({req_op, req_warp, req_valids, req_rs1, req_rs2, req_pc_next});
			end
			credits = credits + int'(credit_return) - int'(req_valid);
		end
	end

	// called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic send_request(input opcode_t op, input warp_id_t warp,
			input thread_mask_t valids, input lane_data_t rs1, input word_t rs2,
			input pc_t pc_next);
		while (credits == 0) begin
			@(posedge clk);
			#1;
		end
		req_valid   = 1'b1;
		req_op      = op;
		req_warp    = warp;
		req_valids  = valids;
		req_rs1     = rs1;
		req_rs2     = rs2;
		req_pc_next = pc_next;
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	// drain the buffer, then read back every warp
	task automatic sweep_queries();
		while (pending.size() != 0) begin
			@(posedge clk);
			#1;
		end
		for (int w = 0; w < NUM_WARPS; w++) begin
			query_warp = warp_id_t'(w);
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		logic [31:0] rnd;
		lane_data_t  rs1;
		opcode_t     op;
		warp_id_t    warp;
		seed        = 32'hbbda_91d2;
		rst_n       = 1'b0;
		req_valid   = 1'b0;
		req_op      = OP_TMC;
		req_warp    = '0;
		req_valids  = '0;
		req_rs1     = '0;
		req_rs2     = '0;
		req_pc_next = '0;
		query_warp  = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		sweep_queries();

		send_request(OP_TMC, 2'd0, 4'b0001, pack_lanes(0, 0, 0, 3), 0, 0);
		sweep_queries();
		send_request(OP_TMC, 2'd0, 4'b0001, pack_lanes(0, 0, 0, 7), 0, 0);
		sweep_queries();
		send_request(OP_WSPAWN, 2'd0, 4'b0001, pack_lanes(0, 0, 0, 4), 32'h100, 0);
		sweep_queries();

		// divergent split, two joins, then a uniform split and an empty join
		send_request(OP_TMC, 2'd1, 4'b0001, pack_lanes(0, 0, 0, 4), 0, 0);
		send_request(OP_SPLIT, 2'd1, 4'b1111, pack_lanes(0, 1, 0, 1), 0, 32'h200);
		sweep_queries();
		send_request(OP_JOIN, 2'd1, 4'b1111, pack_lanes(0, 0, 0, 0), 0, 0);
		sweep_queries();
		send_request(OP_JOIN, 2'd1, 4'b1111, pack_lanes(0, 0, 0, 0), 0, 0);
		sweep_queries();
		send_request(OP_SPLIT, 2'd1, 4'b1111, pack_lanes(1, 1, 1, 1), 0, 32'h300);
		sweep_queries();
		send_request(OP_JOIN, 2'd1, 4'b1111, pack_lanes(0, 0, 0, 0), 0, 0);
		sweep_queries();

		send_request(OP_BAR, 2'd0, 4'b0001, pack_lanes(0, 0, 0, 0), 0, 0);
		sweep_queries();
		send_request(OP_BAR, 2'd1, 4'b0001, pack_lanes(0, 0, 0, 0), 0, 0);
		send_request(OP_BAR, 2'd2, 4'b0001, pack_lanes(0, 0, 0, 0), 0, 0);
		sweep_queries();
		send_request(OP_BAR, 2'd3, 4'b0001, pack_lanes(0, 0, 0, 0), 0, 0);
		sweep_queries();
		send_request(OP_TMC, 2'd3, 4'b0001, pack_lanes(0, 0, 0, 0), 0, 0);
		sweep_queries();

		for (int i = 0; i < NUM_RANDOM; i++) begin
			rnd  = $random(seed);
			op   = opcode_t'(rnd[10:8] % 3'd5);
			warp = rnd[13:12];
			// a parked warp may only arrive at a barrier again
			if (m_stalled[warp] && (op == OP_TMC || op == OP_SPLIT || op == OP_JOIN)) begin
				op = OP_BAR;
			end
			rs1 = pack_lanes({31'd0, rnd[22]}, {31'd0, rnd[21]}, {31'd0, rnd[20]},
				{29'd0, rnd[2:0]});
			send_request(op, warp, rnd[19:16], rs1, $random(seed), $random(seed));
			if (op == OP_BAR || i % 4 == 3) begin
				sweep_queries();
			end
		end
		sweep_queries();

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
design/warp_pkg.sv
design/gpgpu_inst.sv
design/warp_ctl_fsm.sv
design/spawn_counter.sv
design/warp_state_regs.sv
design/barrier_table.sv
design/warp_ctl_top.sv
tb/warp_ctl_props.sv
tb/warp_ctl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module warp_ctl_tb -f flist.f

status=0
./obj_dir/Vwarp_ctl_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation ok"
